// File: all.f
source/soc_pkg.sv
source/mem_if.sv
source/bus_ctrl.sv
source/boot_rom.sv
source/sram_mem.sv
source/clint_timer.sv
source/dbg_reset_unit.sv
source/soc_harness.sv
test/tb_soc_harness.sv

// File: run.sh
#!/usr/bin/env bash
# Build the harness testbench with Verilator, run it and look for the pass line.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module tb_soc_harness \
    -o sim_tb_soc_harness; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/sim_tb_soc_harness 2>&1); then
  echo "$sim_out"
  echo "simulation exited with an error status"
  exit 1
fi

echo "$sim_out"

if grep -qxF ">>> PASS" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// File: test/soc_cases.txt
# name kind addr be wdata err exp  (all numbers hex)
# read/write: exp is rsp_rdata_o; rtc: addr is pulse count, exp is timer_irq_o; ipi: exp is ipi_o
dram_full write 80000000 ff 1122334455667788 0 0
dram_low write 80000000 0f aaaaaaaabbbbbbbb 0 0
dram_merge read 80000000 00 0 0 11223344bbbbbbbb
dram_full2 write 80000008 ff 0123456789abcdef 0 0
dram_edges write 80000008 81 ffeeddccbbaa9988 0 0
dram_merge2 read 80000008 00 0 0 ff23456789abcd88
dram_burst burst 80000100 00 10 0 0
rom_w0 read 00010000 00 0 0 0010041bf1402573
rom_w1 read 00010008 00 0 0 0000059701f41413
rom_w12 read 00010060 00 0 0 deadbeefcafef00d
rom_w13 read 00010068 00 0 0 0123456789abcdef
rom_w15 read 00010078 00 0 0 ffffffff00000000
rom_w16 read 00010080 00 0 0 0
rom_wr_ignored write 00010000 ff ffffffffffffffff 0 0
rom_w0_again read 00010000 00 0 0 0010041bf1402573
unmapped_rd read 40000000 00 0 1 0
unmapped_wr write 10000000 ff 1234 1 0
mtime_zero write 0200bff8 ff 0 0 0
mtimecmp_5 write 02004000 ff 5 0 0
rtc_four rtc 4 00 0 0 0
rtc_fifth rtc 1 00 0 0 1
mtime_read read 0200bff8 00 0 0 5
msip_set write 02000000 01 1 0 0
ipi_high ipi 0 00 0 0 1
msip_read read 02000000 00 0 0 1
msip_clear write 02000000 01 0 0 0
ipi_low ipi 0 00 0 0 0
msip_set2 write 02000000 01 1 0 0
ipi_high2 ipi 0 00 0 0 1
ndm_pulse ndm 0 00 0 0 0
ipi_after_ndm ipi 0 00 0 0 0
irq_after_ndm rtc 0 00 0 0 0
mtime_after_ndm read 0200bff8 00 0 0 0
mtimecmp_after_ndm read 02004000 00 0 0 ffffffffffffffff
dram_survives read 80000000 00 0 0 11223344bbbbbbbb

// File: test/tb_soc_harness.sv
/*
  Testbench for the system harness. Checks the debug gate after reset, then
  replays the case file step by step as the bus master.
*/
`timescale 1ns/1ps

module tb_soc_harness
  import soc_pkg::*;
();

  localparam int unsigned NumWords       = 1024;
  localparam int unsigned DbgDelayCycles = 20;
  localparam int          RspTimeout     = 8;
  localparam int          LevelTimeout   = 12;

  logic  clk_i;
  logic  rst_ni;
  logic  rtc_i;
  logic  ndmreset_i;
  logic  dbg_req_i;
  logic  dbg_en_i;
  logic  bus_req_i;
  logic  bus_we_i;
  addr_t bus_addr_i;
  be_t   bus_be_i;
  data_t bus_wdata_i;
  logic  rsp_valid_o;
  logic  rsp_err_o;
  data_t rsp_rdata_o;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  dbg_req_o;

  integer seed = 80;
  int     step_count = 0;
  // expected dram words for the random burst
  data_t  dram_model [addr_t];

  soc_harness #(
    .NumWords       ( NumWords       ),
    .DbgDelayCycles ( DbgDelayCycles )
  ) dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .rtc_i       ( rtc_i       ),
    .ndmreset_i  ( ndmreset_i  ),
    .dbg_req_i   ( dbg_req_i   ),
    .dbg_en_i    ( dbg_en_i    ),
    .bus_req_i   ( bus_req_i   ),
    .bus_we_i    ( bus_we_i    ),
    .bus_addr_i  ( bus_addr_i  ),
    .bus_be_i    ( bus_be_i    ),
    .bus_wdata_i ( bus_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .dbg_req_o   ( dbg_req_o   )
  );

  always #5 clk_i = ~clk_i;

  task automatic fail_now(string what);
    $display("%0s", what);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // byte lanes with enable set take the new data
  function automatic data_t merge_lanes(data_t prev, data_t nxt, be_t be);
    data_t mask;
    for (int i = 0; i < BeWidth; i++) begin
      mask[i*8 +: 8] = {8{be[i]}};
    end
    return (prev & ~mask) | (nxt & mask);
  endfunction

  // ----------------------------------------
  // bus and pin helpers
  // ----------------------------------------
  task automatic bus_access(string name, logic we, addr_t addr, be_t be, data_t wdata,
                            logic err, data_t exp);
    logic got;
    got = 1'b0;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_be_i    <= be;
    bus_wdata_i <= wdata;
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    bus_we_i  <= 1'b0;
    for (int i = 0; i < RspTimeout && !got; i++) begin
      @(negedge clk_i);
      got = rsp_valid_o;
    end
    assert (got) else fail_now($sformatf("no response to request %0s", name));
    assert (rsp_err_o === err) else
      fail_now($sformatf("mismatch %0s expected %0b actual %0b", name, err, rsp_err_o));
    assert (rsp_rdata_o === exp) else
      fail_now($sformatf("mismatch %0s expected %h actual %h", name, exp, rsp_rdata_o));
    // one response per request
    @(negedge clk_i);
    assert (rsp_valid_o === 1'b0) else
      fail_now($sformatf("response to %0s stayed valid for more than one cycle", name));
  endtask

  task automatic pulse_rtc(int count);
    repeat (count) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (4) @(posedge clk_i);
    end
  endtask

  // system reset releases two edges after the request drops
  task automatic pulse_ndmreset();
    @(posedge clk_i);
    ndmreset_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    ndmreset_i <= 1'b0;
    repeat (3) @(posedge clk_i);
  endtask

  // high levels are awaited, low levels must hold
  task automatic wait_level(string name, logic on_irq, logic expv);
    logic level;
    logic ok;
    level = 1'b0;
    ok    = !expv;
    for (int i = 0; i < LevelTimeout && (expv ? !ok : 1'b1); i++) begin
      @(negedge clk_i);
      level = on_irq ? timer_irq_o : ipi_o;
      if (expv && level) ok = 1'b1;
      if (!expv && level !== 1'b0) ok = 1'b0;
    end
    assert (ok) else
      fail_now($sformatf("mismatch %0s expected %0b actual %0b", name, expv, level));
  endtask

  // full writes first so that every lane is known, then partial writes, then reads
  task automatic run_burst(string name, addr_t base, int count);
    logic  ops_we [$];
    addr_t ops_addr [$];
    be_t   ops_be [$];
    data_t ops_wdata [$];
    data_t ops_exp [$];
    addr_t a;
    data_t d;
    be_t   b;
    for (int pass = 0; pass < 3; pass++) begin
      for (int i = 0; i < count; i++) begin
        a = base + addr_t'(i * BeWidth);
        d = {$random(seed), $random(seed)};
        b = (pass == 0) ? 8'hff : be_t'($random(seed));
        ops_we.push_back(pass != 2);
        ops_addr.push_back(a);
        ops_be.push_back(b);
        ops_wdata.push_back(d);
        if (pass == 0) dram_model[a] = d;
        if (pass == 1) dram_model[a] = merge_lanes(dram_model[a], d, b);
        ops_exp.push_back((pass == 2) ? dram_model[a] : '0);
      end
    end
    for (int k = 0; k <= ops_we.size(); k++) begin
      @(posedge clk_i);
      bus_req_i <= (k < ops_we.size());
      if (k < ops_we.size()) begin
        bus_we_i    <= ops_we[k];
        bus_addr_i  <= ops_addr[k];
        bus_be_i    <= ops_be[k];
        bus_wdata_i <= ops_wdata[k];
      end
      if (k > 0) begin
        @(negedge clk_i);
        assert (rsp_valid_o) else
          fail_now($sformatf("burst %0s lost the response of beat %0d", name, k - 1));
        assert (rsp_err_o === 1'b0) else
          fail_now($sformatf("mismatch %0s[%0d] expected 0 actual %0b", name, k - 1,
                             rsp_err_o));
        assert (rsp_rdata_o === ops_exp[k-1]) else
          fail_now($sformatf("mismatch %0s[%0d] expected %h actual %h", name, k - 1,
                             ops_exp[k-1], rsp_rdata_o));
      end
    end
    bus_we_i <= 1'b0;
  endtask

  task automatic check_debug_gate();
    logic up;
    up = 1'b0;
    for (int c = 1; c <= 15; c++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      assert (dbg_req_o === 1'b0) else
        fail_now($sformatf("mismatch dbg_window expected 0 actual %0b", dbg_req_o));
    end
    for (int c = 16; c <= 25 && !up; c++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      up = dbg_req_o;
    end
    assert (up) else fail_now("dbg_req_o did not rise after the boot window");
    @(posedge clk_i);
    dbg_en_i <= 1'b0;
    @(negedge clk_i);
    assert (dbg_req_o === 1'b0) else
      fail_now($sformatf("mismatch dbg_disabled expected 0 actual %0b", dbg_req_o));
    @(posedge clk_i);
    dbg_req_i <= 1'b0;
  endtask

  task automatic run_step(string name, string kind, addr_t addr, be_t be, data_t wdata,
                          logic err, data_t exp);
    step_count++;
    if (kind == "write") begin
      bus_access(name, 1'b1, addr, be, wdata, err, exp);
    end else if (kind == "read") begin
      bus_access(name, 1'b0, addr, be, wdata, err, exp);
    end else if (kind == "rtc") begin
      pulse_rtc(int'(addr));
      wait_level(name, 1'b1, exp[0]);
    end else if (kind == "ipi") begin
      wait_level(name, 1'b0, exp[0]);
    end else if (kind == "ndm") begin
      pulse_ndmreset();
    end else if (kind == "burst") begin
      run_burst(name, addr, int'(wdata));
    end else begin
      fail_now($sformatf("case %0s has an unknown step kind %0s", name, kind));
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : main
    int    fd;
    int    rc;
    string line;
    string name;
    string kind;
    addr_t addr;
    be_t   be;
    data_t wdata;
    logic  err;
    data_t exp;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    rtc_i       = 1'b0;
    ndmreset_i  = 1'b0;
    dbg_req_i   = 1'b1;
    dbg_en_i    = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_be_i    = '0;
    bus_wdata_i = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_debug_gate();

    fd = $fopen("test/soc_cases.txt", "r");
    if (fd == 0) fail_now("could not open the case file test/soc_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 1 && line[0] != "#") begin
        rc = $sscanf(line, "%s %s %h %h %h %h %h", name, kind, addr, be, wdata, err, exp);
        if (rc != 7) fail_now($sformatf("case file line is malformed: %0s", line));
        run_step(name, kind, addr, be, wdata, err, exp);
      end
    end
    $fclose(fd);
    if (step_count == 0) fail_now("the case file held no steps");

    repeat (2) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: source/soc_harness.sv
/*
  Top of the memory-mapped harness: bus controller, boot rom, dram, timer
  and the debug/reset unit. An external master drives the bus strobes.
*/
`timescale 1ns/1ps

module soc_harness
  import soc_pkg::*;
#(
  parameter int unsigned NumWords       = 1024,
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  rtc_i,
  input  logic  ndmreset_i,
  input  logic  dbg_req_i,
  input  logic  dbg_en_i,
  input  logic  bus_req_i,
  input  logic  bus_we_i,
  input  addr_t bus_addr_i,
  input  be_t   bus_be_i,
  input  data_t bus_wdata_i,
  output logic  rsp_valid_o,
  output logic  rsp_err_o,
  output data_t rsp_rdata_o,
  output logic  timer_irq_o,
  output logic  ipi_o,
  output logic  dbg_req_o
);

  logic sys_rst_n;

  mem_if rom_bus ();
  mem_if clint_bus ();
  mem_if dram_bus ();

  // ----------------------------------------
  // reset and debug
  // ----------------------------------------
  dbg_reset_unit #(
    .DbgDelayCycles ( DbgDelayCycles )
  ) i_dbg_reset_unit (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .dbg_req_i  ( dbg_req_i  ),
    .dbg_en_i   ( dbg_en_i   ),
    .sys_rst_no ( sys_rst_n  ),
    .dbg_req_o  ( dbg_req_o  )
  );

  // ----------------------------------------
  // bus
  // ----------------------------------------
  bus_ctrl #(
    .NumWords ( NumWords )
  ) i_bus_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .bus_req_i   ( bus_req_i   ),
    .bus_we_i    ( bus_we_i    ),
    .bus_addr_i  ( bus_addr_i  ),
    .bus_be_i    ( bus_be_i    ),
    .bus_wdata_i ( bus_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rom_bus     ( rom_bus     ),
    .clint_bus   ( clint_bus   ),
    .dram_bus    ( dram_bus    )
  );

  // ----------------------------------------
  // targets
  // ----------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i   ),
    .rom_bus ( rom_bus )
  );

  // dram keeps its contents across a non-debug reset
  sram_mem #(
    .NumWords ( NumWords )
  ) i_sram_mem (
    .clk_i    ( clk_i    ),
    .dram_bus ( dram_bus )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .rtc_i       ( rtc_i       ),
    .clint_bus   ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

// File: source/dbg_reset_unit.sv
/*
  Builds the system reset from power-on reset and the non-debug reset request,
  and holds off debug requests until the boot window has passed.
*/
`timescale 1ns/1ps

module dbg_reset_unit #(
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic dbg_req_i,
  input  logic dbg_en_i,
  output logic sys_rst_no,
  output logic dbg_req_o
);

  localparam int unsigned CntWidth =
    (DbgDelayCycles > 0) ? $clog2(DbgDelayCycles + 1) : 1;

  logic                rst_async_n;
  logic [1:0]          sync_q;
  logic [CntWidth-1:0] cnt_q;

  // ----------------------------------------
  // system reset
  // ----------------------------------------
  // assert at once, release two edges later
  assign rst_async_n = rst_ni && !ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_async_n) begin
    if (!rst_async_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  // ----------------------------------------
  // boot window
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DbgDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - CntWidth'(1);
    end
  end

  assign dbg_req_o = (cnt_q == '0) && dbg_en_i && dbg_req_i;

endmodule

// File: source/clint_timer.sv
/*
  Core-local timer block with msip, mtimecmp and mtime registers.
  mtime counts rising edges of the real-time clock after synchronization.
*/
`timescale 1ns/1ps

module clint_timer
  import soc_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rtc_i,
  mem_if.mem   clint_bus,
  output logic timer_irq_o,
  output logic ipi_o
);

  localparam addr_t MsipWord     = MsipOffset >> ByteOffBits;
  localparam addr_t MtimecmpWord = MtimecmpOffset >> ByteOffBits;
  localparam addr_t MtimeWord    = MtimeOffset >> ByteOffBits;

  logic  [2:0] rtc_q;
  logic        rtc_rise;
  logic        wr_en;
  logic        msip_q;
  data_t       mtimecmp_q;
  data_t       mtime_q;
  data_t       rdata_q;
  logic        irq_q;

  // two sync stages plus one for edge detect
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  assign rtc_rise = rtc_q[1] && !rtc_q[2];
  assign wr_en    = clint_bus.req && clint_bus.we;

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
      irq_q      <= 1'b0;
    end else begin
      if (wr_en && clint_bus.addr == MsipWord && clint_bus.be[0]) begin
        msip_q <= clint_bus.wdata[0];
      end
      if (wr_en && clint_bus.addr == MtimecmpWord) begin
        mtimecmp_q <= be_merge(mtimecmp_q, clint_bus.wdata, clint_bus.be);
      end
      // a bus write to mtime wins over the tick
      if (wr_en && clint_bus.addr == MtimeWord) begin
        mtime_q <= be_merge(mtime_q, clint_bus.wdata, clint_bus.be);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + data_t'(1);
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (clint_bus.req) begin
      case (clint_bus.addr)
        MsipWord:     rdata_q <= {{(DataWidth-1){1'b0}}, msip_q};
        MtimecmpWord: rdata_q <= mtimecmp_q;
        MtimeWord:    rdata_q <= mtime_q;
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign clint_bus.rdata = rdata_q;
  assign timer_irq_o     = irq_q;
  assign ipi_o           = msip_q;

endmodule

// File: source/sram_mem.sv
/*
  Byte-enabled DRAM model with a single port and registered read data.
  Contents are not initialized and survive any system reset.
*/
`timescale 1ns/1ps

module sram_mem
  import soc_pkg::*;
#(
  parameter int unsigned NumWords = 1024
) (
  input logic clk_i,
  mem_if.mem  dram_bus
);

  localparam int unsigned IdxWidth = $clog2(NumWords);

  data_t                mem [NumWords];
  data_t                rdata_q;
  logic  [IdxWidth-1:0] idx;

  // decoder already limits the offset to the array size
  assign idx = dram_bus.addr[IdxWidth-1:0];

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (dram_bus.req && dram_bus.we) begin
      mem[idx] <= be_merge(mem[idx], dram_bus.wdata, dram_bus.be);
    end
  end

  // read returns the word as it was before any write on this edge
  always_ff @(posedge clk_i) begin
    if (dram_bus.req) begin
      rdata_q <= mem[idx];
    end
  end

  assign dram_bus.rdata = rdata_q;

endmodule

// File: source/boot_rom.sv
/*
  Fixed boot table answering reads on the rom port one cycle after the request.
*/
`timescale 1ns/1ps

module boot_rom
  import soc_pkg::*;
(
  input logic clk_i,
  mem_if.mem  rom_bus
);

  localparam data_t Table [RomWords] = '{
    64'h0010_041b_f140_2573, 64'h0000_0597_01f4_1413,
    64'h0100_006f_0205_8593, 64'h0000_0000_1050_0073,
    64'h0000_0297_ffdf_f06f, 64'h0102_8293_3030_2073,
    64'h3442_9073_3052_9073, 64'h0000_0013_3004_6073,
    64'h8000_0537_0000_0013, 64'h0005_0067_0000_0013,
    64'h0200_0737_0007_3023, 64'h0047_0713_0000_0013,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'h0000_0000_0000_0001, 64'hffff_ffff_0000_0000
  };

  data_t rdata_q;

  // writes land here too and are ignored
  always_ff @(posedge clk_i) begin
    if (rom_bus.req) begin
      if (rom_bus.addr < RomWords) begin
        rdata_q <= Table[rom_bus.addr[$clog2(RomWords)-1:0]];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rom_bus.rdata = rdata_q;

endmodule

// File: source/bus_ctrl.sv
/*
  Address decoder and response path of the harness bus.
  Forwards each request to one target and returns its response a cycle later.
*/
`timescale 1ns/1ps

module bus_ctrl
  import soc_pkg::*;
#(
  parameter int unsigned NumWords = 1024
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  bus_req_i,
  input  logic  bus_we_i,
  input  addr_t bus_addr_i,
  input  be_t   bus_be_i,
  input  data_t bus_wdata_i,
  output logic  rsp_valid_o,
  output logic  rsp_err_o,
  output data_t rsp_rdata_o,
  mem_if.ctrl   rom_bus,
  mem_if.ctrl   clint_bus,
  mem_if.ctrl   dram_bus
);

  localparam addr_t DramLength = addr_t'(NumWords * BeWidth);

  region_e region;
  addr_t   base;
  region_e region_q;
  logic    valid_q;
  logic    we_q;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  always_comb begin
    region = REGION_NONE;
    base   = '0;
    if (bus_addr_i >= RomBase && bus_addr_i < RomBase + RomLength) begin
      region = REGION_ROM;
      base   = RomBase;
    end else if (bus_addr_i >= ClintBase && bus_addr_i < ClintBase + ClintLength) begin
      region = REGION_CLINT;
      base   = ClintBase;
    end else if (bus_addr_i >= DramBase && bus_addr_i < DramBase + DramLength) begin
      region = REGION_DRAM;
      base   = DramBase;
    end
  end

  // same payload to every target, only one strobe fires
  assign rom_bus.req   = bus_req_i && (region == REGION_ROM);
  assign clint_bus.req = bus_req_i && (region == REGION_CLINT);
  assign dram_bus.req  = bus_req_i && (region == REGION_DRAM);

  assign rom_bus.we    = bus_we_i;
  assign clint_bus.we  = bus_we_i;
  assign dram_bus.we   = bus_we_i;

  assign rom_bus.addr   = (bus_addr_i - base) >> ByteOffBits;
  assign clint_bus.addr = (bus_addr_i - base) >> ByteOffBits;
  assign dram_bus.addr  = (bus_addr_i - base) >> ByteOffBits;

  assign rom_bus.be   = bus_be_i;
  assign clint_bus.be = bus_be_i;
  assign dram_bus.be  = bus_be_i;

  assign rom_bus.wdata   = bus_wdata_i;
  assign clint_bus.wdata = bus_wdata_i;
  assign dram_bus.wdata  = bus_wdata_i;

  // ----------------------------------------
  // response
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      we_q     <= 1'b0;
      region_q <= REGION_NONE;
    end else begin
      valid_q  <= bus_req_i;
      we_q     <= bus_we_i;
      region_q <= region;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_err_o   = valid_q && (region_q == REGION_NONE);

  // writes and errors answer with zero data
  always_comb begin
    rsp_rdata_o = '0;
    if (valid_q && !we_q) begin
      case (region_q)
        REGION_ROM:   rsp_rdata_o = rom_bus.rdata;
        REGION_CLINT: rsp_rdata_o = clint_bus.rdata;
        REGION_DRAM:  rsp_rdata_o = dram_bus.rdata;
        default:      rsp_rdata_o = '0;
      endcase
    end
  end

endmodule

// File: source/mem_if.sv
/*
  Strobe-based request port between the bus controller and one target.
  The target answers every request with read data one cycle later.
*/
`timescale 1ns/1ps

interface mem_if
  import soc_pkg::*;
();

  logic  req;
  logic  we;
  // word offset inside the target region
  addr_t addr;
  be_t   be;
  data_t wdata;
  data_t rdata;

  modport ctrl (
    output req, we, addr, be, wdata,
    input  rdata
  );

  modport mem (
    input  req, we, addr, be, wdata,
    output rdata
  );

endinterface

// File: source/soc_pkg.sv
/*
  Shared address map, bus widths and region type for the system harness.
  Imported by every RTL block that decodes or carries bus traffic.
*/
package soc_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 64;
  localparam int unsigned BeWidth     = DataWidth / 8;
  localparam int unsigned ByteOffBits = $clog2(BeWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam addr_t RomBase   = 32'h0001_0000;
  localparam addr_t RomLength = 32'h0000_1000;
  // only the first words of the rom hold code
  localparam int unsigned RomWords = 16;

  localparam addr_t ClintBase      = 32'h0200_0000;
  localparam addr_t ClintLength    = 32'h0000_C000;
  localparam addr_t MsipOffset     = 32'h0000_0000;
  localparam addr_t MtimecmpOffset = 32'h0000_4000;
  localparam addr_t MtimeOffset    = 32'h0000_BFF8;

  // dram length follows the NumWords parameter
  localparam addr_t DramBase = 32'h8000_0000;

  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_CLINT,
    REGION_DRAM,
    REGION_NONE
  } region_e;

  // merge write data over an old word, one byte lane per enable bit
  function automatic data_t be_merge(data_t old_word, data_t new_word, be_t be);
    data_t res;
    res = old_word;
    for (int i = 0; i < BeWidth; i++) begin
      if (be[i]) res[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return res;
  endfunction

endpackage
